//--- tb/id_ex_vectors.txt
// instr pc_next flush wb_en wb_addr wb_data, then expected alu_out flags(z,n,v)
// mem_write_data {mem_en,mem_write} wb{rd,reg_write,mem_to_reg,hlt,pcs}
0000 0002 1 1 1 7fff 0000 0 0000 0 00
0000 0004 1 1 2 0001 0000 0 0000 0 00
0000 0006 1 1 3 8000 0000 0 0000 0 00
0000 0008 1 1 4 00f0 0000 0 0000 0 00
0000 000a 1 1 5 0f0f 0000 0 0000 0 00
1822 000c 0 0 0 0000 0000 4 0000 0 88
1732 000e 0 0 0 0000 7fff 1 0000 0 78
0612 0010 0 0 0 0000 8000 3 0000 0 68
2945 0012 0 0 0 0000 0fff 3 0000 0 98
3a45 0014 0 0 0 0000 0000 7 0000 0 a8
4b45 0016 0 0 0 0000 0fff 3 0000 0 b8
5c54 0018 0 0 0 0000 f0f0 3 0000 0 c8
6d3f 001a 0 0 0 0000 0001 3 0000 0 d8
7e33 001c 0 0 0 0000 f000 3 0000 0 e8
6c21 001e 0 0 0 0000 0000 7 0000 0 c8
a45a 0020 0 0 0 0000 005a 7 0000 0 48
b5a5 0022 0 0 0 0000 a50f 7 0000 0 58
8642 0024 0 0 0 0000 00f4 7 0000 2 6c
874f 0026 0 0 0 0000 00ee 7 0000 2 7c
9513 0028 0 0 0 0000 8005 7 0f0f 3 50
0612 002a 1 0 0 0000 0000 7 0000 0 00
9513 002c 1 0 0 0000 0000 7 0000 0 00
0980 002e 0 1 8 1234 1234 0 0000 0 98
0b82 0030 0 0 0 0000 1235 0 0000 0 b8
0902 0032 0 1 0 ffff 0001 0 0000 0 98
0a00 0034 0 0 0 0000 0000 4 0000 0 a8
e300 0042 0 0 0 0000 0042 4 0000 0 39
f000 0038 0 0 0 0000 0000 4 0000 0 02

//--- cpu_id_ex_top.f
hw/cpu_pkg.sv
hw/reg_file.sv
hw/decode_unit.sv
hw/id_ex_pipe_reg.sv
hw/execute_unit.sv
hw/cpu_id_ex_top.sv
tb/cpu_id_ex_sva.sv
tb/tb_cpu_id_ex_top.sv

//--- Bender.yml
package:
  name: cpu_id_ex

sources:
  - hw/cpu_pkg.sv
  - hw/reg_file.sv
  - hw/decode_unit.sv
  - hw/id_ex_pipe_reg.sv
  - hw/execute_unit.sv
  - hw/cpu_id_ex_top.sv
  - target: test
    files:
      - tb/cpu_id_ex_sva.sv
      - tb/tb_cpu_id_ex_top.sv

//--- tb/tb_cpu_id_ex_top.sv
module tb_cpu_id_ex_top;
  import cpu_pkg::*;

  localparam int clk_period     = 4;   // Time units per clock
  localparam int reset_cycles   = 10;
  localparam int max_vectors    = 64;  // Room in the vector memory
  localparam int fields_per_vec = 11;  // Hex words on each vector line

  // Word positions within one vector line
  localparam int f_instr   = 0;
  localparam int f_pc      = 1;
  localparam int f_flush   = 2;
  localparam int f_wb_en   = 3;
  localparam int f_wb_addr = 4;
  localparam int f_wb_data = 5;
  localparam int f_alu     = 6;
  localparam int f_flags   = 7;
  localparam int f_wdata   = 8;
  localparam int f_mem     = 9;
  localparam int f_wb      = 10;

  // Expected EX/MEM contents and flags of one instruction
  typedef struct packed {
    logic [data_w-1:0] alu_out;
    logic [data_w-1:0] pc_next;  // Passed through untouched, even by a flush
    logic [2:0]        flags;    // Z, N, V
    logic [data_w-1:0] wdata;
    logic [1:0]        mem_ctl;  // mem_en, mem_write
    logic [7:0]        wb;       // Whole write-back bundle
  } expect_t;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  flush;
  instr_u                instr;
  logic [data_w-1:0]     pc_next;
  logic                  wb_en;
  logic [reg_addr_w-1:0] wb_addr;
  logic [data_w-1:0]     wb_data;
  ex_result_t            ex_out;
  flags_t                flags;

  logic [16:0] vec_mem [max_vectors*fields_per_vec];  // Bit 16 set marks a word the file left alone
  int          num_vectors = 0;
  logic        vectors_loaded = 1'b0;
  int          check_count = 0;
  int          error_count = 0;

  // Two-deep delay line matching the decode to EX/MEM latency
  expect_t exp_line [2];
  int      idx_line [2];
  logic    valid_line [2];

  cpu_id_ex_top UUT (
    .clk(clk), .rst_n(rst_n), .flush(flush), .instr(instr), .pc_next(pc_next),
    .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data), .ex_out(ex_out), .flags(flags)
  );

  always #(clk_period/2) clk = ~clk;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////
  task automatic compare_field(input string name, input logic [15:0] actual,
                               input logic [15:0] expected, input int vec);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] vector %0d %s: got 0x%h, expected 0x%h", vec, name, actual, expected);
    end
  endtask

  task automatic apply_vector(input int idx);
    int base;
    base    = idx * fields_per_vec;
    instr   <= vec_mem[base + f_instr][15:0];  // Sampled by ID/EX at the next edge
    pc_next <= vec_mem[base + f_pc][15:0];
    flush   <= vec_mem[base + f_flush][0];
    wb_en   <= vec_mem[base + f_wb_en][0];
    wb_addr <= vec_mem[base + f_wb_addr][3:0];
    wb_data <= vec_mem[base + f_wb_data][15:0];
  endtask

  // Bubbles that drain the pipeline after the last vector
  task automatic drive_idle();
    flush <= 1'b1;
    wb_en <= 1'b0;
  endtask

  function automatic expect_t expected_of(input int idx);
    int      base;
    expect_t e;
    base      = idx * fields_per_vec;
    e.alu_out = vec_mem[base + f_alu][15:0];
    e.pc_next = vec_mem[base + f_pc][15:0];
    e.flags   = vec_mem[base + f_flags][2:0];
    e.wdata   = vec_mem[base + f_wdata][15:0];
    e.mem_ctl = vec_mem[base + f_mem][1:0];
    e.wb      = vec_mem[base + f_wb][7:0];
    return e;
  endfunction

  task automatic check_outputs(input expect_t e, input int vec);
    compare_field("alu_out", ex_out.alu_out, e.alu_out, vec);
    compare_field("pc_next", ex_out.pc_next, e.pc_next, vec);
    compare_field("flags", {13'b0, flags}, {13'b0, e.flags}, vec);
    compare_field("mem_write_data", ex_out.mem.mem_write_data, e.wdata, vec);
    compare_field("mem_en/mem_write", {14'b0, ex_out.mem.mem_en, ex_out.mem.mem_write},
                  {14'b0, e.mem_ctl}, vec);
    compare_field("wb", {8'b0, ex_out.wb}, {8'b0, e.wb}, vec);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial begin
    int sva_fails;
    rst_n   = 1'b0;
    flush   = 1'b1;  // Bubbles until the first vector arrives
    instr   = '0;
    pc_next = '0;
    wb_en   = 1'b0;
    wb_addr = '0;
    wb_data = '0;
    for (int k = 0; k < max_vectors*fields_per_vec; k++)
      vec_mem[k] = {1'b1, 16'(k)};
    $readmemh("tb/id_ex_vectors.txt", vec_mem);
    while (num_vectors < max_vectors && !vec_mem[num_vectors*fields_per_vec][16])
      num_vectors++;
    if (num_vectors == 0) begin
      error_count++;
      $display("No vectors could be read from tb/id_ex_vectors.txt");
    end else if (vec_mem[num_vectors*fields_per_vec - 1][16]) begin
      error_count++;
      $display("The last line of tb/id_ex_vectors.txt is incomplete");
    end
    vectors_loaded = 1'b1;
    valid_line[0]  = 1'b0;
    valid_line[1]  = 1'b0;

    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;

    for (int j = 0; j < num_vectors + 2; j++) begin
      @(posedge clk);
      if (j < num_vectors)
        apply_vector(j);
      else
        drive_idle();
      @(negedge clk);  // Outputs are settled away from the active edge
      if (valid_line[1])
        check_outputs(exp_line[1], idx_line[1]);
      exp_line[1]   = exp_line[0];
      idx_line[1]   = idx_line[0];
      valid_line[1] = valid_line[0];
      valid_line[0] = (j < num_vectors);
      idx_line[0]   = j;
      if (j < num_vectors)
        exp_line[0] = expected_of(j);
    end

    sva_fails = UUT.u_id_ex.u_sva.fail_count;
    $display("Vectors: %0d, checks: %0d, value errors: %0d, assertion failures: %0d",
             num_vectors, check_count, error_count, sva_fails);
    if (error_count + sva_fails == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

  // Watchdog sized from the number of vectors read
  initial begin
    wait (vectors_loaded);
    #((num_vectors + 20) * clk_period);
    $display("Timed out at %0t before all vectors were checked", $time);
    $display("Test failures found");
    $finish;
  end

endmodule

//--- tb/cpu_id_ex_sva.sv
module cpu_id_ex_sva (
  input logic                        clk,
  input logic                        rst_n,
  input logic                        flush,
  input logic [cpu_pkg::data_w-1:0]  id_ex_pc_next,
  input cpu_pkg::ex_ctrl_t           id_ex_ex_ctrl,
  input cpu_pkg::mem_ctrl_t          id_ex_mem_ctrl,
  input cpu_pkg::wb_ctrl_t           id_ex_wb_ctrl
);

  int unsigned fail_count = 0;  // Failed assertions, read from the testbench

  //////////////////////////////////////////////////
  // ID/EX register properties
  //////////////////////////////////////////////////
  // A flushed slot holds all-zero bundles one cycle later
  a_flush_bubble: assert property (@(posedge clk) disable iff (!rst_n)
    flush |=> (id_ex_ex_ctrl == '0) && (id_ex_mem_ctrl == '0) && (id_ex_wb_ctrl == '0))
    else begin
      fail_count++;
      $error("ID/EX bundles not zero after a flush");
    end

  // HLT never writes a register
  a_hlt_no_write: assert property (@(posedge clk) disable iff (!rst_n)
    !(id_ex_wb_ctrl.reg_write && id_ex_wb_ctrl.hlt))
    else begin
      fail_count++;
      $error("reg_write and hlt both set in ID/EX");
    end

  a_reset_zero: assert property (@(posedge clk)
    !rst_n |-> (id_ex_pc_next == '0) && (id_ex_ex_ctrl == '0)
               && (id_ex_mem_ctrl == '0) && (id_ex_wb_ctrl == '0))
    else begin
      fail_count++;
      $error("ID/EX outputs not zero during reset");
    end

endmodule

bind id_ex_pipe_reg cpu_id_ex_sva u_sva (
  .clk(clk), .rst_n(rst_n), .flush(flush), .id_ex_pc_next(id_ex_pc_next),
  .id_ex_ex_ctrl(id_ex_ex_ctrl), .id_ex_mem_ctrl(id_ex_mem_ctrl), .id_ex_wb_ctrl(id_ex_wb_ctrl)
);

//--- hw/cpu_id_ex_top.sv
module cpu_id_ex_top (
  input  logic                            clk,
  input  logic                            rst_n,    // Asynchronous, active low
  input  logic                            flush,    // Bubble the instruction being captured
  input  cpu_pkg::instr_u                 instr,    // Instruction word to decode
  input  logic [cpu_pkg::data_w-1:0]      pc_next,  // Next PC of that instruction
  input  logic                            wb_en,    // Write-back port enable
  input  logic [cpu_pkg::reg_addr_w-1:0]  wb_addr,  // Write-back port register
  input  logic [cpu_pkg::data_w-1:0]      wb_data,  // Write-back port data
  output cpu_pkg::ex_result_t             ex_out,   // EX/MEM register contents
  output cpu_pkg::flags_t                 flags     // Z, N and V flags
);
  import cpu_pkg::*;

  //////////////////////////////////////////////////
  // Decode stage wiring
  //////////////////////////////////////////////////
  logic [reg_addr_w-1:0] rd_addr1;  // Source register indices
  logic [reg_addr_w-1:0] rd_addr2;
  logic [data_w-1:0]     rd_data1;  // Operands read back
  logic [data_w-1:0]     rd_data2;
  ex_ctrl_t              ex_ctrl;   // Bundles into ID/EX
  mem_ctrl_t             mem_ctrl;
  wb_ctrl_t              wb_ctrl;

  // ID/EX outputs into execute
  logic [data_w-1:0]     id_ex_pc_next;
  ex_ctrl_t              id_ex_ex_ctrl;
  mem_ctrl_t             id_ex_mem_ctrl;
  wb_ctrl_t              id_ex_wb_ctrl;

  decode_unit u_decode (
    .instr(instr), .rd_addr1(rd_addr1), .rd_addr2(rd_addr2),
    .rd_data1(rd_data1), .rd_data2(rd_data2),
    .ex_ctrl(ex_ctrl), .mem_ctrl(mem_ctrl), .wb_ctrl(wb_ctrl)
  );

  // The write-back stage reaches the register file through the top-level port
  reg_file u_reg_file (
    .clk(clk), .rst_n(rst_n),
    .rd_addr1(rd_addr1), .rd_addr2(rd_addr2), .rd_data1(rd_data1), .rd_data2(rd_data2),
    .wr_en(wb_en), .wr_addr(wb_addr), .wr_data(wb_data)
  );

  id_ex_pipe_reg u_id_ex (
    .clk(clk), .rst_n(rst_n), .flush(flush), .pc_next(pc_next),
    .ex_ctrl(ex_ctrl), .mem_ctrl(mem_ctrl), .wb_ctrl(wb_ctrl),
    .id_ex_pc_next(id_ex_pc_next), .id_ex_ex_ctrl(id_ex_ex_ctrl),
    .id_ex_mem_ctrl(id_ex_mem_ctrl), .id_ex_wb_ctrl(id_ex_wb_ctrl)
  );

  execute_unit u_execute (
    .clk(clk), .rst_n(rst_n), .pc_next(id_ex_pc_next),
    .ex_ctrl(id_ex_ex_ctrl), .mem_ctrl(id_ex_mem_ctrl), .wb_ctrl(id_ex_wb_ctrl),
    .ex_out(ex_out), .flags(flags)
  );

endmodule

//--- hw/execute_unit.sv
module execute_unit (
  input  logic                        clk,
  input  logic                        rst_n,     // Asynchronous, active low
  input  logic [cpu_pkg::data_w-1:0]  pc_next,   // Next PC from ID/EX, the PCS result
  input  cpu_pkg::ex_ctrl_t           ex_ctrl,   // ALU operands and controls
  input  cpu_pkg::mem_ctrl_t          mem_ctrl,  // Passed on to EX/MEM
  input  cpu_pkg::wb_ctrl_t           wb_ctrl,   // Passed on to EX/MEM
  output cpu_pkg::ex_result_t         ex_out,    // EX/MEM register
  output cpu_pkg::flags_t             flags      // Z, N and V flag register
);
  import cpu_pkg::*;

  logic [data_w-1:0] op_a;     // First ALU operand
  logic [data_w-1:0] op_b;     // Second operand, register or immediate
  logic [data_w-1:0] sum;      // op_a plus op_b
  logic [data_w-1:0] diff;     // op_a minus op_b
  logic              ovf;      // Signed overflow of add or sub
  logic [data_w-1:0] alu_res;  // ALU result

  assign op_a = ex_ctrl.alu_in1;
  assign op_b = ex_ctrl.alu_src ? ex_ctrl.alu_imm : ex_ctrl.src2_data;
  assign sum  = op_a + op_b;
  assign diff = op_a - op_b;

  //////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////
  always_comb begin
    alu_res = '0;
    ovf     = 1'b0;
    unique case (ex_ctrl.alu_op)
      op_add: begin
        alu_res = sum;
        ovf     = (op_a[15] == op_b[15]) && (sum[15] != op_a[15]);  // Like signs, sign changed
      end
      op_sub: begin
        alu_res = diff;
        ovf     = (op_a[15] != op_b[15]) && (diff[15] != op_a[15]);  // Unlike signs, sign changed
      end
      op_xor:        alu_res = op_a ^ op_b;
      op_and:        alu_res = op_a & op_b;
      op_or:         alu_res = op_a | op_b;
      op_sll:        alu_res = op_a << op_b[3:0];
      op_srl:        alu_res = op_a >> op_b[3:0];
      op_sra:        alu_res = $signed(op_a) >>> op_b[3:0];
      op_lw, op_sw:  alu_res = sum;                        // Effective address
      op_llb:        alu_res = {op_a[15:8], op_b[7:0]};    // Low byte replaced
      op_lhb:        alu_res = {op_b[7:0], op_a[7:0]};     // High byte replaced
      op_pcs:        alu_res = pc_next;
      default:       alu_res = '0;                         // HLT and unused codes
    endcase
  end

  //////////////////////////////////////////////////
  // Flag and EX/MEM registers, same edge
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags <= '0;
    end else begin
      if (ex_ctrl.z_en)
        flags.z <= (alu_res == '0);
      if (ex_ctrl.nv_en) begin
        flags.n <= alu_res[15];  // Sign of the result
        flags.v <= ovf;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_out <= '0;
    end else begin
      ex_out.alu_out <= alu_res;
      ex_out.pc_next <= pc_next;
      ex_out.mem     <= mem_ctrl;
      ex_out.wb      <= wb_ctrl;
    end
  end

endmodule

//--- hw/id_ex_pipe_reg.sv
module id_ex_pipe_reg (
  input  logic                        clk,
  input  logic                        rst_n,           // Asynchronous, active low
  input  logic                        flush,           // Turn the captured instruction into a bubble
  input  logic [cpu_pkg::data_w-1:0]  pc_next,         // Next PC from the fetch side
  input  cpu_pkg::ex_ctrl_t           ex_ctrl,         // Execute controls from decode
  input  cpu_pkg::mem_ctrl_t          mem_ctrl,        // Memory controls from decode
  input  cpu_pkg::wb_ctrl_t           wb_ctrl,         // Write-back controls from decode
  output logic [cpu_pkg::data_w-1:0]  id_ex_pc_next,   // Registered next PC
  output cpu_pkg::ex_ctrl_t           id_ex_ex_ctrl,   // Registered execute controls
  output cpu_pkg::mem_ctrl_t          id_ex_mem_ctrl,  // Registered memory controls
  output cpu_pkg::wb_ctrl_t           id_ex_wb_ctrl    // Registered write-back controls
);

  //////////////////////////////////////////////////
  // Next PC, loaded every cycle and kept on flush
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      id_ex_pc_next <= '0;
    else
      id_ex_pc_next <= pc_next;
  end

  //////////////////////////////////////////////////
  // Control bundles
  //////////////////////////////////////////////////
  // A zero bundle writes nothing, touches no memory and enables no flag
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_ex_ex_ctrl  <= '0;
      id_ex_mem_ctrl <= '0;
      id_ex_wb_ctrl  <= '0;
    end else if (flush) begin
      id_ex_ex_ctrl  <= '0;  // Bubble in place of the instruction
      id_ex_mem_ctrl <= '0;
      id_ex_wb_ctrl  <= '0;
    end else begin
      id_ex_ex_ctrl  <= ex_ctrl;
      id_ex_mem_ctrl <= mem_ctrl;
      id_ex_wb_ctrl  <= wb_ctrl;
    end
  end

endmodule

//--- hw/decode_unit.sv
module decode_unit (
  input  cpu_pkg::instr_u                  instr,     // Instruction word from IF/ID
  output logic [cpu_pkg::reg_addr_w-1:0]   rd_addr1,  // Register file read port 1 address
  output logic [cpu_pkg::reg_addr_w-1:0]   rd_addr2,  // Register file read port 2 address
  input  logic [cpu_pkg::data_w-1:0]       rd_data1,  // Register file read port 1 data
  input  logic [cpu_pkg::data_w-1:0]       rd_data2,  // Register file read port 2 data
  output cpu_pkg::ex_ctrl_t                ex_ctrl,   // Execute stage controls
  output cpu_pkg::mem_ctrl_t               mem_ctrl,  // Memory stage controls
  output cpu_pkg::wb_ctrl_t                wb_ctrl    // Write-back stage controls
);
  import cpu_pkg::*;

  logic [3:0]        opcode;   // Opcode field, common to both formats
  logic              is_shift; // SLL, SRL or SRA
  logic              is_mem;   // LW or SW
  logic              is_byte;  // LLB or LHB
  logic [data_w-1:0] imm;      // Immediate after extension

  assign opcode   = instr.r.opcode;
  assign is_shift = (opcode == op_sll) || (opcode == op_srl) || (opcode == op_sra);
  assign is_mem   = (opcode == op_lw) || (opcode == op_sw);
  assign is_byte  = (opcode == op_llb) || (opcode == op_lhb);

  //////////////////////////////////////////////////
  // Register selection
  //////////////////////////////////////////////////
  // Byte loads modify rd in place, so rd is read as the first operand
  assign rd_addr1 = is_byte ? instr.i.rd : instr.r.rs;

  // A store keeps its data register in the rd field, since rt holds the offset
  assign rd_addr2 = (opcode == op_sw) ? instr.r.rd : instr.r.rt;

  //////////////////////////////////////////////////
  // Immediate formation
  //////////////////////////////////////////////////
  always_comb begin
    if (is_shift) begin
      imm = {{(data_w-4){1'b0}}, instr.r.rt};  // Shift amount is unsigned
    end else if (is_mem) begin
      // Signed word offset turned into a byte offset
      imm = {{(data_w-5){instr.r.rt[3]}}, instr.r.rt, 1'b0};
    end else if (is_byte) begin
      imm = {{(data_w-8){1'b0}}, instr.i.imm8};  // Byte value for LLB or LHB
    end else begin
      imm = '0;
    end
  end

  //////////////////////////////////////////////////
  // Control bundles
  //////////////////////////////////////////////////
  always_comb begin
    ex_ctrl.src1      = rd_addr1;
    ex_ctrl.src2      = rd_addr2;
    ex_ctrl.alu_in1   = rd_data1;
    ex_ctrl.alu_imm   = imm;
    ex_ctrl.src2_data = rd_data2;
    ex_ctrl.alu_op    = opcode;                   // ALU uses the opcode encoding directly
    ex_ctrl.alu_src   = is_shift | is_mem | is_byte;
    ex_ctrl.z_en      = (opcode <= op_sra);       // Every arithmetic, logic and shift op
    ex_ctrl.nv_en     = (opcode == op_add) || (opcode == op_sub);

    // Only a store carries data toward memory
    mem_ctrl.mem_write_data = (opcode == op_sw) ? rd_data2 : '0;
    mem_ctrl.mem_en         = is_mem;
    mem_ctrl.mem_write      = (opcode == op_sw);

    wb_ctrl.rd         = instr.r.rd;
    wb_ctrl.mem_to_reg = (opcode == op_lw);
    wb_ctrl.hlt        = (opcode == op_hlt);
    wb_ctrl.pcs        = (opcode == op_pcs);

    // Codes 12 and 13 and the SW and HLT ops leave the register file alone
    unique case (opcode)
      op_add, op_sub, op_xor, op_and, op_or,
      op_sll, op_srl, op_sra, op_lw,
      op_llb, op_lhb, op_pcs: wb_ctrl.reg_write = 1'b1;
      default:                wb_ctrl.reg_write = 1'b0;
    endcase
  end

endmodule

//--- hw/reg_file.sv
module reg_file (
  input  logic                            clk,
  input  logic                            rst_n,     // Asynchronous, active low
  input  logic [cpu_pkg::reg_addr_w-1:0]  rd_addr1,
  input  logic [cpu_pkg::reg_addr_w-1:0]  rd_addr2,
  output logic [cpu_pkg::data_w-1:0]      rd_data1,
  output logic [cpu_pkg::data_w-1:0]      rd_data2,
  input  logic                            wr_en,     // Write-back port enable
  input  logic [cpu_pkg::reg_addr_w-1:0]  wr_addr,
  input  logic [cpu_pkg::data_w-1:0]      wr_data
);
  import cpu_pkg::*;

  logic [data_w-1:0] regs [num_regs];  // Register array
  logic              wr_ok;            // Write that is not aimed at r0

  assign wr_ok = wr_en && (wr_addr != '0);

  // Writes land at the clock edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_ok) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Reads are combinational, and r0 is forced to zero
  // A write in the same cycle is passed straight to a matching read
  always_comb begin
    if (rd_addr1 == '0)
      rd_data1 = '0;
    else if (wr_ok && (wr_addr == rd_addr1))
      rd_data1 = wr_data;                   // Write-through bypass
    else
      rd_data1 = regs[rd_addr1];

    if (rd_addr2 == '0)
      rd_data2 = '0;
    else if (wr_ok && (wr_addr == rd_addr2))
      rd_data2 = wr_data;
    else
      rd_data2 = regs[rd_addr2];
  end

endmodule

//--- hw/cpu_pkg.sv
package cpu_pkg;

  //////////////////////////////////////////////////
  // Widths fixed by the instruction set
  //////////////////////////////////////////////////
  localparam int data_w     = 16;  // Data path and address width
  localparam int reg_addr_w = 4;   // Register index width
  localparam int num_regs   = 16;  // Registers r0 to r15

  //////////////////////////////////////////////////
  // Opcodes
  //////////////////////////////////////////////////
  localparam logic [3:0] op_add = 4'd0;   // Register add
  localparam logic [3:0] op_sub = 4'd1;   // Register subtract
  localparam logic [3:0] op_xor = 4'd2;
  localparam logic [3:0] op_and = 4'd3;
  localparam logic [3:0] op_or  = 4'd4;
  localparam logic [3:0] op_sll = 4'd5;   // Shift left logical by a 4-bit immediate
  localparam logic [3:0] op_srl = 4'd6;   // Shift right logical by a 4-bit immediate
  localparam logic [3:0] op_sra = 4'd7;   // Shift right arithmetic by a 4-bit immediate
  localparam logic [3:0] op_lw  = 4'd8;   // Load word at base plus offset times two
  localparam logic [3:0] op_sw  = 4'd9;   // Store word at base plus offset times two
  localparam logic [3:0] op_llb = 4'd10;  // Replace the low byte of rd
  localparam logic [3:0] op_lhb = 4'd11;  // Replace the high byte of rd
  localparam logic [3:0] op_pcs = 4'd14;  // Write the next PC to rd
  localparam logic [3:0] op_hlt = 4'd15;  // Halt the processor

  //////////////////////////////////////////////////
  // Instruction formats
  //////////////////////////////////////////////////
  // Register format, where shifts and memory ops treat rt as a 4-bit immediate
  typedef struct packed {
    logic [3:0]            opcode;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rs;
    logic [reg_addr_w-1:0] rt;
  } r_instr_t;

  // Byte load format used by LLB and LHB
  typedef struct packed {
    logic [3:0]            opcode;
    logic [reg_addr_w-1:0] rd;
    logic [7:0]            imm8;
  } i_instr_t;

  // One instruction word seen through both formats
  typedef union packed {
    r_instr_t r;
    i_instr_t i;
  } instr_u;

  //////////////////////////////////////////////////
  // Control bundles carried down the pipeline
  //////////////////////////////////////////////////
  typedef struct packed {
    logic [reg_addr_w-1:0] src1;       // First source register index
    logic [reg_addr_w-1:0] src2;       // Second source register index
    logic [data_w-1:0]     alu_in1;    // First ALU operand
    logic [data_w-1:0]     alu_imm;    // Formed immediate
    logic [data_w-1:0]     src2_data;  // Second source register data
    logic [3:0]            alu_op;     // ALU operation, same code as the opcode
    logic                  alu_src;    // Take the immediate as the second operand
    logic                  z_en;       // Update the Z flag
    logic                  nv_en;      // Update the N and V flags
  } ex_ctrl_t;

  typedef struct packed {
    logic [data_w-1:0] mem_write_data;  // Data to store on SW
    logic              mem_en;          // Data memory access
    logic              mem_write;       // Access is a write
  } mem_ctrl_t;

  typedef struct packed {
    logic [reg_addr_w-1:0] rd;          // Destination register
    logic                  reg_write;   // Write rd at write-back
    logic                  mem_to_reg;  // Write-back data comes from memory
    logic                  hlt;
    logic                  pcs;
  } wb_ctrl_t;

  typedef struct packed {
    logic z;  // Result was zero
    logic n;  // Result was negative
    logic v;  // Signed overflow
  } flags_t;

  // Contents of the EX/MEM register
  typedef struct packed {
    logic [data_w-1:0] alu_out;
    logic [data_w-1:0] pc_next;
    mem_ctrl_t         mem;
    wb_ctrl_t          wb;
  } ex_result_t;

endpackage
